//--- source/periph_macros.svh
`ifndef PERIPH_MACROS_SVH
`define PERIPH_MACROS_SVH

// Bus widths
`define PERIPH_ADDR_W   16
`define PERIPH_DATA_W   32
`define PERIPH_BE_W     4

// ------------------------------
// Address map
// ------------------------------
`define BOOT_BASE       16'h0000
`define BOOT_LEN        16'h0400   // 256 words
`define GPIO_BASE       16'h2000
`define GPIO_LEN        16'h0100

// GPIO and queueing
`define LED_W           8
`define REQ_FIFO_DEPTH  4
`define BAD_DATA        32'hDEADBEEF   // Read data of absent registers

`endif

//--- source/periph_pkg.sv
`include "periph_macros.svh"

package periph_pkg;

    // Request as issued by the bus master
    typedef struct packed {
        logic [`PERIPH_ADDR_W-1:0] addr;
        logic                      we;
        logic [`PERIPH_DATA_W-1:0] wdata;
        logic [`PERIPH_BE_W-1:0]   be;
    } periph_req_t;

    typedef enum logic [1:0] {
        TGT_BOOT = 2'd0,
        TGT_GPIO = 2'd1,
        TGT_NONE = 2'd2   // No region claims the address
    } target_e;

    // Request tagged with its target by the decoder
    typedef struct packed {
        periph_req_t req;
        target_e     tgt;
    } dec_req_t;

    typedef struct packed {
        logic [`PERIPH_DATA_W-1:0] rdata;
        logic                      err;
    } periph_rsp_t;

    typedef enum logic [1:0] {
        EX_IDLE     = 2'd0,
        EX_RAM_WAIT = 2'd1,
        EX_RESP     = 2'd2
    } exec_state_e;

endpackage

//--- source/periph_addr_decode.sv
`timescale 1ns/1ps
`include "periph_macros.svh"

module periph_addr_decode
    import periph_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        req_valid_i,
    input  periph_req_t req_i,
    output logic        req_ready_o,
    output logic        dec_valid_o,
    output dec_req_t    dec_req_o,
    input  logic        dec_ready_i
);

    localparam logic [`PERIPH_ADDR_W-1:0] BOOT_MASK = `BOOT_LEN - 16'd1;
    localparam logic [`PERIPH_ADDR_W-1:0] GPIO_MASK = `GPIO_LEN - 16'd1;

    logic     dec_valid_q;
    dec_req_t dec_req_q;

    // First matching region wins
    function automatic target_e decode_target(logic [`PERIPH_ADDR_W-1:0] addr);
        target_e tgt;
        tgt = TGT_NONE;
        if ((addr & ~BOOT_MASK) == `BOOT_BASE)
            tgt = TGT_BOOT;
        else if ((addr & ~GPIO_MASK) == `GPIO_BASE)
            tgt = TGT_GPIO;
        return tgt;
    endfunction

    // Stage empty or draining this cycle
    assign req_ready_o = !dec_valid_q || dec_ready_i;

    // ------------------------------
    // Request register
    // ------------------------------
    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
            dec_valid_q <= 1'b0;
        else if (req_ready_o)
            dec_valid_q <= req_valid_i;
    end

    always_ff @(posedge clk_i)
    begin
        if (req_valid_i && req_ready_o)
        begin
            dec_req_q.req <= req_i;
            dec_req_q.tgt <= decode_target(req_i.addr);
        end
    end

    assign dec_valid_o = dec_valid_q;
    assign dec_req_o   = dec_req_q;

endmodule

//--- source/periph_req_fifo.sv
`timescale 1ns/1ps
`include "periph_macros.svh"

module periph_req_fifo
    import periph_pkg::*;
#(
    parameter int DEPTH = `REQ_FIFO_DEPTH
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     wr_valid_i,
    input  dec_req_t wr_data_i,
    output logic     wr_ready_o,
    output logic     rd_valid_o,
    output dec_req_t rd_data_o,
    input  logic     rd_ready_i
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    dec_req_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;

    // Wraps at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    assign wr_ready_o = (count != CNT_W'(DEPTH));
    assign rd_valid_o = (count != '0);
    assign wr_en      = wr_valid_i && wr_ready_o;
    assign rd_en      = rd_valid_o && rd_ready_i;
    assign rd_data_o  = mem[rd_ptr];   // Head entry, shown one cycle after write

    always_ff @(posedge clk_i)
    begin
        if (wr_en)
            mem[wr_ptr] <= wr_data_i;
    end

    // ------------------------------
    // Pointers and occupancy
    // ------------------------------
    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= next_ptr(wr_ptr);
            if (rd_en)
                rd_ptr <= next_ptr(rd_ptr);
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Idle or simultaneous push and pop
            endcase
        end
    end

endmodule

//--- source/boot_ram.sv
`timescale 1ns/1ps
`include "periph_macros.svh"

module boot_ram (
    input  logic                      clk_i,
    input  logic                      en_i,
    input  logic                      we_i,
    input  logic [7:0]                word_addr_i,
    input  logic [`PERIPH_BE_W-1:0]   be_i,
    input  logic [`PERIPH_DATA_W-1:0] wdata_i,
    output logic [`PERIPH_DATA_W-1:0] rdata_o
);

    localparam int WORDS = `BOOT_LEN / (`PERIPH_DATA_W / 8);

    logic [`PERIPH_DATA_W-1:0] mem [WORDS];

    // ------------------------------
    // Single port, byte lanes
    // ------------------------------
    always_ff @(posedge clk_i)
    begin
        if (en_i)
        begin
            if (we_i)
            begin
                for (int i = 0; i < `PERIPH_BE_W; i++)
                begin
                    if (be_i[i])
                        mem[word_addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
                end
            end
            else
            begin
                rdata_o <= mem[word_addr_i];   // Ready next cycle
            end
        end
    end

endmodule

//--- source/gpio_regs.sv
`timescale 1ns/1ps
`include "periph_macros.svh"

module gpio_regs (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      en_i,
    input  logic                      we_i,
    input  logic [2:0]                reg_idx_i,
    input  logic [`PERIPH_BE_W-1:0]   be_i,
    input  logic [`PERIPH_DATA_W-1:0] wdata_i,
    input  logic [`LED_W-1:0]         dip_switches_i,
    output logic [`PERIPH_DATA_W-1:0] rdata_o,
    output logic [`LED_W-1:0]         leds_o
);

    localparam logic [2:0] LED_IDX = 3'd0;   // LEDs on write, switches on read

    logic [`LED_W-1:0] leds_q;

    // Read mux, no register stage
    always_comb
    begin
        if (reg_idx_i == LED_IDX)
            rdata_o = {{(`PERIPH_DATA_W - `LED_W){1'b0}}, dip_switches_i};
        else
            rdata_o = `BAD_DATA;
    end

    // ------------------------------
    // LED register
    // ------------------------------
    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
            leds_q <= '0;
        else if (en_i && we_i && (reg_idx_i == LED_IDX) && be_i[0])
            leds_q <= wdata_i[`LED_W-1:0];   // Other indices drop writes
    end

    assign leds_o = leds_q;

endmodule

//--- source/periph_target_exec.sv
`timescale 1ns/1ps
`include "periph_macros.svh"

module periph_target_exec
    import periph_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              q_valid_i,
    input  dec_req_t          q_req_i,
    output logic              q_ready_o,
    output logic              rsp_valid_o,
    output periph_rsp_t       rsp_o,
    input  logic              rsp_ready_i,
    input  logic [`LED_W-1:0] dip_switches_i,
    output logic [`LED_W-1:0] leds_o
);

    exec_state_e               state_q;
    exec_state_e               state_d;
    periph_rsp_t               rsp_q;
    periph_rsp_t               rsp_d;
    logic                      q_fire;
    logic                      ram_en;
    logic                      gpio_en;
    logic [`PERIPH_DATA_W-1:0] ram_rdata;
    logic [`PERIPH_DATA_W-1:0] gpio_rdata;

    assign q_ready_o = (state_q == EX_IDLE);
    assign q_fire    = q_valid_i && q_ready_o;
    assign ram_en    = q_fire && (q_req_i.tgt == TGT_BOOT);
    assign gpio_en   = q_fire && (q_req_i.tgt == TGT_GPIO);

    boot_ram u_boot_ram (
        .clk_i       (clk_i),
        .en_i        (ram_en),
        .we_i        (q_req_i.req.we),
        .word_addr_i (q_req_i.req.addr[9:2]),   // Byte address to word index
        .be_i        (q_req_i.req.be),
        .wdata_i     (q_req_i.req.wdata),
        .rdata_o     (ram_rdata)
    );

    gpio_regs u_gpio_regs (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .en_i           (gpio_en),
        .we_i           (q_req_i.req.we),
        .reg_idx_i      (q_req_i.req.addr[5:3]),
        .be_i           (q_req_i.req.be),
        .wdata_i        (q_req_i.req.wdata),
        .dip_switches_i (dip_switches_i),
        .rdata_o        (gpio_rdata),
        .leds_o         (leds_o)
    );

    // ------------------------------
    // Executor FSM
    // ------------------------------
    always_comb
    begin
        state_d = state_q;
        rsp_d   = rsp_q;
        case (state_q)
            EX_IDLE:
            begin
                if (q_fire)
                begin
                    rsp_d.rdata = '0;   // Writes answer with zero
                    rsp_d.err   = 1'b0;
                    state_d     = EX_RESP;
                    case (q_req_i.tgt)
                        TGT_BOOT:
                        begin
                            if (!q_req_i.req.we)
                                state_d = EX_RAM_WAIT;
                        end
                        TGT_GPIO:
                        begin
                            if (!q_req_i.req.we)
                                rsp_d.rdata = gpio_rdata;
                        end
                        default:
                        begin
                            rsp_d.err = 1'b1;
                            if (!q_req_i.req.we)
                                rsp_d.rdata = `BAD_DATA;
                        end
                    endcase
                end
            end
            EX_RAM_WAIT:
            begin
                // RAM output valid one cycle after the strobe
                rsp_d.rdata = ram_rdata;
                rsp_d.err   = 1'b0;
                state_d     = EX_RESP;
            end
            EX_RESP:
            begin
                if (rsp_ready_i)
                    state_d = EX_IDLE;
            end
            default: state_d = EX_IDLE;
        endcase
    end

    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
            state_q <= EX_IDLE;
        else
            state_q <= state_d;
    end

    always_ff @(posedge clk_i)
    begin
        rsp_q <= rsp_d;   // Stays put in EX_RESP
    end

    assign rsp_valid_o = (state_q == EX_RESP);
    assign rsp_o       = rsp_q;

endmodule

//--- source/periph_subsystem.sv
`timescale 1ns/1ps
`include "periph_macros.svh"

module periph_subsystem
    import periph_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              req_valid_i,
    input  periph_req_t       req_i,
    output logic              req_ready_o,
    output logic              rsp_valid_o,
    output periph_rsp_t       rsp_o,
    input  logic              rsp_ready_i,
    input  logic [`LED_W-1:0] dip_switches_i,
    output logic [`LED_W-1:0] leds_o
);

    // Decoder to FIFO
    logic     dec_valid;
    logic     dec_ready;
    dec_req_t dec_req;

    // FIFO to executor
    logic     q_valid;
    logic     q_ready;
    dec_req_t q_req;

    periph_addr_decode u_addr_decode (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .req_ready_o (req_ready_o),
        .dec_valid_o (dec_valid),
        .dec_req_o   (dec_req),
        .dec_ready_i (dec_ready)
    );

    periph_req_fifo #(
        .DEPTH (`REQ_FIFO_DEPTH)
    ) u_req_fifo (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .wr_valid_i (dec_valid),
        .wr_data_i  (dec_req),
        .wr_ready_o (dec_ready),
        .rd_valid_o (q_valid),
        .rd_data_o  (q_req),
        .rd_ready_i (q_ready)
    );

    periph_target_exec u_target_exec (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .q_valid_i      (q_valid),
        .q_req_i        (q_req),
        .q_ready_o      (q_ready),
        .rsp_valid_o    (rsp_valid_o),
        .rsp_o          (rsp_o),
        .rsp_ready_i    (rsp_ready_i),
        .dip_switches_i (dip_switches_i),
        .leds_o         (leds_o)
    );

endmodule

//--- verif/periph_assertions.sv
`timescale 1ns/1ps

module periph_assertions
    import periph_pkg::*;
(
    input logic        clk_i,
    input logic        rst_n_i,
    input logic        dec_valid_i,
    input dec_req_t    dec_req_i,
    input logic        dec_ready_i,
    input logic        req_ready_i,
    input logic        rsp_valid_i,
    input periph_rsp_t rsp_i,
    input logic        rsp_ready_i
);

    int fail_cnt = 0;   // Failed assertions so far

    // Decoded request held until the FIFO takes it
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
                     dec_valid_i && !dec_ready_i |=> dec_valid_i && $stable(dec_req_i))
    else
    begin
        $error("Decoded request changed while the request FIFO was full");
        fail_cnt++;
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
                     rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_i))
    else
    begin
        $error("Response changed while rsp_ready_i was low");
        fail_cnt++;
    end

    // Idle handshake state out of reset
    assert property (@(posedge clk_i) !rst_n_i |=> !rsp_valid_i && req_ready_i)
    else
    begin
        $error("Handshake outputs not idle after reset");
        fail_cnt++;
    end

endmodule

bind periph_subsystem periph_assertions u_assertions (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .dec_valid_i (dec_valid),
    .dec_req_i   (dec_req),
    .dec_ready_i (dec_ready),
    .req_ready_i (req_ready_o),
    .rsp_valid_i (rsp_valid_o),
    .rsp_i       (rsp_o),
    .rsp_ready_i (rsp_ready_i)
);

//--- verif/periph_checker.sv
`timescale 1ns/1ps
`include "periph_macros.svh"

module periph_checker
    import periph_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              rsp_valid_i,
    input  periph_rsp_t       rsp_i,
    input  logic              rsp_ready_i,
    input  logic [`LED_W-1:0] leds_i,
    output int                pass_cnt_o,
    output int                fail_cnt_o,
    output int                done_cnt_o
);

    // Expected responses, oldest first
    string                     exp_name  [$];
    logic [`PERIPH_DATA_W-1:0] exp_rdata [$];
    logic                      exp_err   [$];
    logic [`LED_W-1:0]         exp_led   [$];
    int                        pass_cnt = 0;
    int                        fail_cnt = 0;
    int                        done_cnt = 0;

    task automatic push_expect(input string name, input logic [`PERIPH_DATA_W-1:0] rdata,
                               input logic err, input logic [`LED_W-1:0] led);
        exp_name.push_back(name);
        exp_rdata.push_back(rdata);
        exp_err.push_back(err);
        exp_led.push_back(led);
    endtask

    // ------------------------------
    // Compare on each response transfer
    // ------------------------------
    always @(posedge clk_i)
    begin
        if (rst_n_i && rsp_valid_i && rsp_ready_i)
        begin
            done_cnt++;
            if (exp_name.size() == 0)
            begin
                $display("Response arrived with no request outstanding");
                fail_cnt++;
            end
            else if (rsp_i.rdata === exp_rdata[0] && rsp_i.err === exp_err[0] &&
                     leds_i === exp_led[0])
            begin
                $display("pass  %s", exp_name[0]);
                pass_cnt++;
            end
            else
            begin
                $display("error %s: expected rdata=%h err=%b leds=%h, actual rdata=%h err=%b leds=%h",
                         exp_name[0], exp_rdata[0], exp_err[0], exp_led[0],
                         rsp_i.rdata, rsp_i.err, leds_i);
                fail_cnt++;
            end
            if (exp_name.size() != 0)
            begin
                void'(exp_name.pop_front());
                void'(exp_rdata.pop_front());
                void'(exp_err.pop_front());
                void'(exp_led.pop_front());
            end
        end
    end

    assign pass_cnt_o = pass_cnt;
    assign fail_cnt_o = fail_cnt;
    assign done_cnt_o = done_cnt;

endmodule

//--- verif/periph_tb.sv
`timescale 1ns/1ps
`include "periph_macros.svh"

module periph_tb
    import periph_pkg::*;
();

    logic              clk = 1'b0;
    logic              rst_n;
    logic              req_valid;
    periph_req_t       req;
    logic              req_ready;
    logic              rsp_valid;
    periph_rsp_t       rsp;
    logic              rsp_ready;
    logic [`LED_W-1:0] dip_switches;
    logic [`LED_W-1:0] leds;
    logic [31:0]       rnd_state = 32'h48fe92e7;
    int                pass_cnt;
    int                fail_cnt;
    int                done_cnt;

    // Stimulus table
    string                     names     [$];
    periph_req_t               reqs      [$];
    logic [`PERIPH_DATA_W-1:0] exp_rdata [$];
    logic                      exp_err   [$];
    logic [`LED_W-1:0]         exp_led   [$];

    always #2 clk = ~clk;   // 4 ns period

    periph_subsystem uut (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .req_valid_i    (req_valid),
        .req_i          (req),
        .req_ready_o    (req_ready),
        .rsp_valid_o    (rsp_valid),
        .rsp_o          (rsp),
        .rsp_ready_i    (rsp_ready),
        .dip_switches_i (dip_switches),
        .leds_o         (leds)
    );

    periph_checker u_checker (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .rsp_valid_i (rsp_valid),
        .rsp_i       (rsp),
        .rsp_ready_i (rsp_ready),
        .leds_i      (leds),
        .pass_cnt_o  (pass_cnt),
        .fail_cnt_o  (fail_cnt),
        .done_cnt_o  (done_cnt)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic add_entry(input string name, input logic [15:0] addr, input logic we,
                             input logic [31:0] wdata, input logic [3:0] be,
                             input logic [31:0] rdata, input logic err, input logic [7:0] led);
        periph_req_t r;
        r.addr  = addr;
        r.we    = we;
        r.wdata = wdata;
        r.be    = be;
        names.push_back(name);
        reqs.push_back(r);
        exp_rdata.push_back(rdata);
        exp_err.push_back(err);
        exp_led.push_back(led);
    endtask

    // Random sink back-pressure, about three cycles in four ready
    always @(posedge clk)
    begin
        #1;
        rnd_state = xorshift32(rnd_state);
        rsp_ready <= (rnd_state[1:0] != 2'b00);
    end

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial
    begin
        rst_n        = 1'b0;
        req_valid    = 1'b0;
        req          = '0;
        rsp_ready    = 1'b0;
        dip_switches = 8'hA5;
        add_entry("ram_wr_full",  16'h0010, 1'b1, 32'h12345678, 4'hF, 32'h0,        1'b0, 8'h00);
        add_entry("ram_rd_full",  16'h0010, 1'b0, 32'h0,        4'hF, 32'h12345678, 1'b0, 8'h00);
        add_entry("ram_wr_known", 16'h0020, 1'b1, 32'hAABBCCDD, 4'hF, 32'h0,        1'b0, 8'h00);
        add_entry("ram_wr_part",  16'h0020, 1'b1, 32'h11223344, 4'h5, 32'h0,        1'b0, 8'h00);
        add_entry("ram_rd_part",  16'h0020, 1'b0, 32'h0,        4'hF, 32'hAA22CC44, 1'b0, 8'h00);
        add_entry("gpio_wr_led",  16'h2000, 1'b1, 32'h0000003C, 4'hF, 32'h0,        1'b0, 8'h3C);
        add_entry("gpio_rd_dip",  16'h2000, 1'b0, 32'h0,        4'hF, 32'h000000A5, 1'b0, 8'h3C);
        add_entry("gpio_rd_idx2", 16'h2010, 1'b0, 32'h0,        4'hF, `BAD_DATA,    1'b0, 8'h3C);
        add_entry("unmapped_rd",  16'h8000, 1'b0, 32'h0,        4'hF, `BAD_DATA,    1'b1, 8'h3C);
        add_entry("unmapped_wr",  16'h8000, 1'b1, 32'h000000FF, 4'hF, 32'h0,        1'b1, 8'h3C);
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;
        for (int i = 0; i < names.size(); i++)
        begin
            req_valid = 1'b1;
            req       = reqs[i];
            @(posedge clk);
            while (!req_ready)
                @(posedge clk);
            u_checker.push_expect(names[i], exp_rdata[i], exp_err[i], exp_led[i]);
            #1;
        end
        req_valid = 1'b0;
        while (done_cnt < names.size())
            @(posedge clk);
        repeat (8) @(posedge clk);   // Room for a stray extra response
        $display("Tests: %0d passed, %0d failed, %0d assertion failures",
                 pass_cnt, fail_cnt, uut.u_assertions.fail_cnt);
        if (fail_cnt == 0 && uut.u_assertions.fail_cnt == 0 && done_cnt == names.size())
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    // Watchdog, 40 cycles per table entry
    initial
    begin
        @(posedge rst_n);
        repeat (names.size() * 40) @(posedge clk);
        $display("Timeout: only %0d of %0d responses arrived", done_cnt, names.size());
        $display("** FAIL **");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+source
source/periph_pkg.sv
source/periph_addr_decode.sv
source/periph_req_fifo.sv
source/boot_ram.sv
source/gpio_regs.sv
source/periph_target_exec.sv
source/periph_subsystem.sv
verif/periph_assertions.sv
verif/periph_checker.sv
verif/periph_tb.sv
